// File: Makefile
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator, run it and check $(LOG)"
	@echo "  clean  remove the build directory and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --assert --timescale 1ns/10ps --top-module mmu_tb \
		-Mdir obj_dir -f mmu.f
	./obj_dir/Vmmu_tb | tee $(LOG)
	grep -q "Test completed successfully" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: mmu.f
+incdir+source
source/mmu_pkg.sv
source/tlb_entry_array.sv
source/tlb_lookup.sv
source/cp0_tlb_regs.sv
source/mmu_top.sv
tb/mmu_tb.sv

// File: source/cp0_tlb_regs.sv
`timescale 1ns/10ps
`default_nettype none

`include "mmu_params.svh"

module cp0_tlb_regs (
    input  logic                     aclk,
    input  logic                     rst_n,
    input  mmu_pkg::tlb_op_e         tlb_op,
    input  logic                     cp0_wen,
    input  mmu_pkg::cp0_sel_e        cp0_wsel,
    input  logic [31:0]              cp0_wdata,
    input  mmu_pkg::cp0_sel_e        cp0_rsel,
    input  logic                     probe_found,
    input  logic [`MMU_INDEX_W-1:0]  probe_index,
    input  mmu_pkg::tlb_entry_t      rd_entry,
    output logic [31:0]              cp0_rdata,
    output logic [`MMU_INDEX_W-1:0]  index,
    output logic [`MMU_VPN2_W-1:0]   entryhi_vpn2,
    output logic [`MMU_ASID_W-1:0]   entryhi_asid,
    output logic [`MMU_PFN_W-1:0]    lo0_pfn,
    output logic [2:0]               lo0_c,
    output logic                     lo0_d,
    output logic                     lo0_v,
    output logic                     lo0_g,
    output logic [`MMU_PFN_W-1:0]    lo1_pfn,
    output logic [2:0]               lo1_c,
    output logic                     lo1_d,
    output logic                     lo1_v,
    output logic                     lo1_g
);

    logic index_p;      // probe failure flag, Index[31]
    logic wr_index;
    logic wr_hi;
    logic wr_lo0;
    logic wr_lo1;
    logic do_tlbp;
    logic do_tlbr;

    assign wr_index = cp0_wen && (cp0_wsel == mmu_pkg::CP0_INDEX);
    assign wr_hi    = cp0_wen && (cp0_wsel == mmu_pkg::CP0_ENTRYHI);
    assign wr_lo0   = cp0_wen && (cp0_wsel == mmu_pkg::CP0_ENTRYLO0);
    assign wr_lo1   = cp0_wen && (cp0_wsel == mmu_pkg::CP0_ENTRYLO1);
    assign do_tlbp  = (tlb_op == mmu_pkg::TLB_P);
    assign do_tlbr  = (tlb_op == mmu_pkg::TLB_R);

    // Index, tlbp result beats mtc0
    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            index_p <= 1'b0;
            index   <= '0;
        end else if (do_tlbp) begin
            index_p <= ~probe_found;
            if (probe_found) begin
                index <= probe_index;   // miss keeps the old index
            end
        end else if (wr_index) begin
            index_p <= cp0_wdata[31];
            index   <= cp0_wdata[`MMU_INDEX_W-1:0];
        end
    end

    // EntryHi
    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            entryhi_vpn2 <= '0;
            entryhi_asid <= '0;
        end else if (do_tlbr) begin
            entryhi_vpn2 <= rd_entry.vpn2;
            entryhi_asid <= rd_entry.asid;
        end else if (wr_hi) begin
            entryhi_vpn2 <= cp0_wdata[31:13];
            entryhi_asid <= cp0_wdata[`MMU_ASID_W-1:0];
        end
    end

    // EntryLo0 and EntryLo1, g copied from the entry on tlbr
    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            {lo0_pfn, lo0_c, lo0_d, lo0_v, lo0_g} <= '0;
            {lo1_pfn, lo1_c, lo1_d, lo1_v, lo1_g} <= '0;
        end else if (do_tlbr) begin
            {lo0_pfn, lo0_c, lo0_d, lo0_v, lo0_g} <= {rd_entry.pfn0, rd_entry.c0,
                                                      rd_entry.d0, rd_entry.v0, rd_entry.g};
            {lo1_pfn, lo1_c, lo1_d, lo1_v, lo1_g} <= {rd_entry.pfn1, rd_entry.c1,
                                                      rd_entry.d1, rd_entry.v1, rd_entry.g};
        end else begin
            if (wr_lo0) begin
                {lo0_pfn, lo0_c, lo0_d, lo0_v, lo0_g} <= cp0_wdata[25:0];
            end
            if (wr_lo1) begin
                {lo1_pfn, lo1_c, lo1_d, lo1_v, lo1_g} <= cp0_wdata[25:0];
            end
        end
    end

    // mfc0 read mux, unused bits zero
    always_comb begin
        cp0_rdata = '0;
        case (cp0_rsel)
            mmu_pkg::CP0_INDEX: begin
                cp0_rdata[31]                = index_p;
                cp0_rdata[`MMU_INDEX_W-1:0]  = index;
            end
            mmu_pkg::CP0_ENTRYHI: begin
                cp0_rdata[31:13]             = entryhi_vpn2;
                cp0_rdata[`MMU_ASID_W-1:0]   = entryhi_asid;
            end
            mmu_pkg::CP0_ENTRYLO0: cp0_rdata[25:0] = {lo0_pfn, lo0_c, lo0_d, lo0_v, lo0_g};
            mmu_pkg::CP0_ENTRYLO1: cp0_rdata[25:0] = {lo1_pfn, lo1_c, lo1_d, lo1_v, lo1_g};
            default: cp0_rdata = '0;
        endcase
    end

    a_op_known: assert property (
        @(posedge aclk) disable iff (!rst_n)
        !$isunknown(tlb_op)
    ) else $error("tlb_op is unknown");

endmodule

`default_nettype wire

// File: source/mmu_params.svh
`ifndef MMU_PARAMS_SVH
`define MMU_PARAMS_SVH

// tlb geometry
`define MMU_ENTRIES     16
`define MMU_INDEX_W     4

// address split for 4 KB pages
`define MMU_VA_W        32
`define MMU_OFFSET_W    12
`define MMU_VPN2_W      19      // va[31:13], one even/odd page pair
`define MMU_PFN_W       20

// address space id
`define MMU_ASID_W      8

`endif

// File: source/mmu_pkg.sv
`default_nettype none

`include "mmu_params.svh"

package mmu_pkg;

    // one tlb entry, even page is page 0
    typedef struct packed {
        logic [`MMU_VPN2_W-1:0] vpn2;
        logic [`MMU_ASID_W-1:0] asid;
        logic                   g;      // global, ignores asid
        logic [`MMU_PFN_W-1:0]  pfn0;
        logic [2:0]             c0;
        logic                   d0;
        logic                   v0;
        logic [`MMU_PFN_W-1:0]  pfn1;
        logic [2:0]             c1;
        logic                   d1;
        logic                   v1;
    } tlb_entry_t;

    // tlb instruction strobe
    typedef enum logic [1:0] {
        TLB_NONE = 2'd0,
        TLB_WI   = 2'd1,    // write entry Index
        TLB_P    = 2'd2,    // probe with EntryHi
        TLB_R    = 2'd3     // read entry Index
    } tlb_op_e;

    // cp0 register select for mtc0 / mfc0
    typedef enum logic [1:0] {
        CP0_INDEX    = 2'd0,
        CP0_ENTRYHI  = 2'd1,
        CP0_ENTRYLO0 = 2'd2,
        CP0_ENTRYLO1 = 2'd3
    } cp0_sel_e;

endpackage

`default_nettype wire

// File: source/mmu_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "mmu_params.svh"

module mmu_top (
    input  logic                   aclk,
    input  logic                   rst_n,
    input  mmu_pkg::tlb_op_e       tlb_op,
    input  logic                   cp0_wen,
    input  mmu_pkg::cp0_sel_e      cp0_wsel,
    input  logic [31:0]            cp0_wdata,
    input  mmu_pkg::cp0_sel_e      cp0_rsel,
    input  logic                   i_req,
    input  logic [`MMU_VA_W-1:0]   i_vaddr,
    input  logic                   d_req,
    input  logic [`MMU_VA_W-1:0]   d_vaddr,
    output logic [31:0]            cp0_rdata,
    output logic                   i_valid,
    output logic                   i_found,
    output logic                   i_v,
    output logic                   i_d,
    output logic [2:0]             i_c,
    output logic [`MMU_VA_W-1:0]   i_paddr,
    output logic                   d_valid,
    output logic                   d_found,
    output logic                   d_v,
    output logic                   d_d,
    output logic [2:0]             d_c,
    output logic [`MMU_VA_W-1:0]   d_paddr
);

    mmu_pkg::tlb_entry_t      entries [0:`MMU_ENTRIES-1];
    mmu_pkg::tlb_entry_t      rd_entry;
    logic                     probe_found;
    logic [`MMU_INDEX_W-1:0]  probe_index;
    logic [`MMU_INDEX_W-1:0]  index;
    logic [`MMU_VPN2_W-1:0]   entryhi_vpn2;
    logic [`MMU_ASID_W-1:0]   entryhi_asid;   // also the current asid for lookups
    logic [`MMU_PFN_W-1:0]    lo0_pfn;
    logic [2:0]               lo0_c;
    logic                     lo0_d;
    logic                     lo0_v;
    logic                     lo0_g;
    logic [`MMU_PFN_W-1:0]    lo1_pfn;
    logic [2:0]               lo1_c;
    logic                     lo1_d;
    logic                     lo1_v;
    logic                     lo1_g;

    cp0_tlb_regs u_cp0_tlb_regs (
        .aclk         (aclk),
        .rst_n        (rst_n),
        .tlb_op       (tlb_op),
        .cp0_wen      (cp0_wen),
        .cp0_wsel     (cp0_wsel),
        .cp0_wdata    (cp0_wdata),
        .cp0_rsel     (cp0_rsel),
        .probe_found  (probe_found),
        .probe_index  (probe_index),
        .rd_entry     (rd_entry),
        .cp0_rdata    (cp0_rdata),
        .index        (index),
        .entryhi_vpn2 (entryhi_vpn2),
        .entryhi_asid (entryhi_asid),
        .lo0_pfn      (lo0_pfn),
        .lo0_c        (lo0_c),
        .lo0_d        (lo0_d),
        .lo0_v        (lo0_v),
        .lo0_g        (lo0_g),
        .lo1_pfn      (lo1_pfn),
        .lo1_c        (lo1_c),
        .lo1_d        (lo1_d),
        .lo1_v        (lo1_v),
        .lo1_g        (lo1_g)
    );

    tlb_entry_array u_tlb_entry_array (
        .aclk         (aclk),
        .rst_n        (rst_n),
        .tlb_op       (tlb_op),
        .index        (index),
        .entryhi_vpn2 (entryhi_vpn2),
        .entryhi_asid (entryhi_asid),
        .lo0_pfn      (lo0_pfn),
        .lo0_c        (lo0_c),
        .lo0_d        (lo0_d),
        .lo0_v        (lo0_v),
        .lo0_g        (lo0_g),
        .lo1_pfn      (lo1_pfn),
        .lo1_c        (lo1_c),
        .lo1_d        (lo1_d),
        .lo1_v        (lo1_v),
        .lo1_g        (lo1_g),
        .entries      (entries),
        .probe_found  (probe_found),
        .probe_index  (probe_index),
        .rd_entry     (rd_entry)
    );

    // instruction fetch port
    tlb_lookup u_fetch_lookup (
        .aclk    (aclk),
        .rst_n   (rst_n),
        .entries (entries),
        .asid    (entryhi_asid),
        .req     (i_req),
        .vaddr   (i_vaddr),
        .valid   (i_valid),
        .found   (i_found),
        .v       (i_v),
        .d       (i_d),
        .c       (i_c),
        .paddr   (i_paddr)
    );

    // data access port, runs alongside fetch
    tlb_lookup u_data_lookup (
        .aclk    (aclk),
        .rst_n   (rst_n),
        .entries (entries),
        .asid    (entryhi_asid),
        .req     (d_req),
        .vaddr   (d_vaddr),
        .valid   (d_valid),
        .found   (d_found),
        .v       (d_v),
        .d       (d_d),
        .c       (d_c),
        .paddr   (d_paddr)
    );

endmodule

`default_nettype wire

// File: source/tlb_entry_array.sv
`timescale 1ns/10ps
`default_nettype none

`include "mmu_params.svh"

module tlb_entry_array (
    input  logic                      aclk,
    input  logic                      rst_n,
    input  mmu_pkg::tlb_op_e          tlb_op,
    input  logic [`MMU_INDEX_W-1:0]   index,
    input  logic [`MMU_VPN2_W-1:0]    entryhi_vpn2,
    input  logic [`MMU_ASID_W-1:0]    entryhi_asid,
    input  logic [`MMU_PFN_W-1:0]     lo0_pfn,
    input  logic [2:0]                lo0_c,
    input  logic                      lo0_d,
    input  logic                      lo0_v,
    input  logic                      lo0_g,
    input  logic [`MMU_PFN_W-1:0]     lo1_pfn,
    input  logic [2:0]                lo1_c,
    input  logic                      lo1_d,
    input  logic                      lo1_v,
    input  logic                      lo1_g,
    output mmu_pkg::tlb_entry_t       entries [0:`MMU_ENTRIES-1],
    output logic                      probe_found,
    output logic [`MMU_INDEX_W-1:0]   probe_index,
    output mmu_pkg::tlb_entry_t       rd_entry
);

    mmu_pkg::tlb_entry_t      entries_q [0:`MMU_ENTRIES-1];
    mmu_pkg::tlb_entry_t      wr_entry;
    logic [`MMU_ENTRIES-1:0]  probe_hit;

    // new entry image from EntryHi / EntryLo0 / EntryLo1
    always_comb begin
        wr_entry      = '0;
        wr_entry.vpn2 = entryhi_vpn2;
        wr_entry.asid = entryhi_asid;
        wr_entry.g    = lo0_g & lo1_g;  // global only if both halves say so
        wr_entry.pfn0 = lo0_pfn;
        wr_entry.c0   = lo0_c;
        wr_entry.d0   = lo0_d;
        wr_entry.v0   = lo0_v;
        wr_entry.pfn1 = lo1_pfn;
        wr_entry.c1   = lo1_c;
        wr_entry.d1   = lo1_d;
        wr_entry.v1   = lo1_v;
    end

    // everything starts as zero, see reset behaviour at the top level
    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `MMU_ENTRIES; i++) begin
                entries_q[i] <= '0;
            end
        end else if (tlb_op == mmu_pkg::TLB_WI) begin
            entries_q[index] <= wr_entry;
        end
    end

    assign entries = entries_q;

    // tlbp match of EntryHi against every entry
    always_comb begin
        for (int i = 0; i < `MMU_ENTRIES; i++) begin
            probe_hit[i] = (entries_q[i].vpn2 == entryhi_vpn2) &&
                           (entries_q[i].g || entries_q[i].asid == entryhi_asid);
        end
    end

    always_comb begin
        probe_index = '0;
        for (int i = 0; i < `MMU_ENTRIES; i++) begin
            if (probe_hit[i]) begin
                probe_index = i[`MMU_INDEX_W-1:0];
            end
        end
    end

    assign probe_found = |probe_hit;

    // tlbr source
    assign rd_entry = entries_q[index];

    // software must never map one address twice
    a_probe_unique: assert property (
        @(posedge aclk) disable iff (!rst_n)
        (tlb_op == mmu_pkg::TLB_P) |-> $onehot0(probe_hit)
    ) else $error("tlbp matched more than one tlb entry");

endmodule

`default_nettype wire

// File: source/tlb_lookup.sv
`timescale 1ns/10ps
`default_nettype none

`include "mmu_params.svh"

module tlb_lookup (
    input  logic                     aclk,
    input  logic                     rst_n,
    input  mmu_pkg::tlb_entry_t      entries [0:`MMU_ENTRIES-1],
    input  logic [`MMU_ASID_W-1:0]   asid,
    input  logic                     req,
    input  logic [`MMU_VA_W-1:0]     vaddr,
    output logic                     valid,
    output logic                     found,
    output logic                     v,
    output logic                     d,
    output logic [2:0]               c,
    output logic [`MMU_VA_W-1:0]     paddr
);

    logic [`MMU_VPN2_W-1:0]  va_vpn2;
    logic                    odd_page;
    logic [`MMU_ENTRIES-1:0] hit;
    logic [`MMU_PFN_W-1:0]   sel_pfn;
    logic [2:0]              sel_c;
    logic                    sel_d;
    logic                    sel_v;

    assign va_vpn2  = vaddr[`MMU_VA_W-1 -: `MMU_VPN2_W];
    assign odd_page = vaddr[`MMU_OFFSET_W];    // bit 12

    // one comparator per entry
    always_comb begin
        for (int i = 0; i < `MMU_ENTRIES; i++) begin
            hit[i] = (entries[i].vpn2 == va_vpn2) &&
                     (entries[i].g || entries[i].asid == asid);
        end
    end

    // page fields of the hit entry, all zero on a miss
    always_comb begin
        sel_pfn = '0;
        sel_c   = '0;
        sel_d   = 1'b0;
        sel_v   = 1'b0;
        for (int i = 0; i < `MMU_ENTRIES; i++) begin
            if (hit[i]) begin
                sel_pfn = odd_page ? entries[i].pfn1 : entries[i].pfn0;
                sel_c   = odd_page ? entries[i].c1   : entries[i].c0;
                sel_d   = odd_page ? entries[i].d1   : entries[i].d0;
                sel_v   = odd_page ? entries[i].v1   : entries[i].v0;
            end
        end
    end

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            valid <= 1'b0;
            found <= 1'b0;
        end else begin
            valid <= req;
            found <= req & (|hit);  // low whenever valid is low
        end
    end

    // result payload, only meaningful with valid
    always_ff @(posedge aclk) begin
        if (req) begin
            v     <= sel_v;
            d     <= sel_d;
            c     <= sel_c;
            paddr <= (|hit) ? {sel_pfn, vaddr[`MMU_OFFSET_W-1:0]} : '0;
        end
    end

    a_fixed_latency: assert property (
        @(posedge aclk) disable iff (!rst_n)
        1'b1 |=> (valid == $past(req))
    ) else $error("lookup valid not exactly one cycle after req");

    a_found_needs_valid: assert property (
        @(posedge aclk) disable iff (!rst_n)
        found |-> valid
    ) else $error("lookup found without valid");

endmodule

`default_nettype wire

// File: tb/mmu_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "mmu_params.svh"

module mmu_tb;

    localparam int N_RW       = 12;
    localparam int N_LOOKUPS  = 120;
    localparam int N_PROBES   = 16;
    localparam int N_READS    = 8;
    localparam int N_CYCLES   = 7 + 2 * N_RW + 5 * `MMU_ENTRIES + N_LOOKUPS
                                + 3 * N_PROBES + 5 * N_READS;
    localparam int TIMEOUT_NS = N_CYCLES * 8 + 400;

    // expected result of one lookup
    typedef struct packed {
        logic        found;
        logic        v;
        logic        d;
        logic [2:0]  c;
        logic [31:0] paddr;
    } lookup_exp_t;

    logic                    aclk;
    logic                    rst_n;
    mmu_pkg::tlb_op_e        tlb_op;
    logic                    cp0_wen;
    mmu_pkg::cp0_sel_e       cp0_wsel;
    logic [31:0]             cp0_wdata;
    mmu_pkg::cp0_sel_e       cp0_rsel;
    logic                    i_req;
    logic [`MMU_VA_W-1:0]    i_vaddr;
    logic                    d_req;
    logic [`MMU_VA_W-1:0]    d_vaddr;
    logic [31:0]             cp0_rdata;
    logic                    i_valid;
    logic                    i_found;
    logic                    i_v;
    logic                    i_d;
    logic [2:0]              i_c;
    logic [`MMU_VA_W-1:0]    i_paddr;
    logic                    d_valid;
    logic                    d_found;
    logic                    d_v;
    logic                    d_d;
    logic [2:0]              d_c;
    logic [`MMU_VA_W-1:0]    d_paddr;

    // reference model state
    mmu_pkg::tlb_entry_t     model_tlb [0:`MMU_ENTRIES-1];
    logic                    m_index_p;
    logic [`MMU_INDEX_W-1:0] m_index;
    logic [`MMU_VPN2_W-1:0]  m_hi_vpn2;
    logic [`MMU_ASID_W-1:0]  m_hi_asid;
    logic [25:0]             m_lo0;     // pfn, c, d, v, g as in the register
    logic [25:0]             m_lo1;
    lookup_exp_t             i_expq [$];
    lookup_exp_t             d_expq [$];
    logic [31:0]             lcg_state;

    mmu_top u_dut (.*);

    initial begin
        aclk = 1'b0;
        forever #4 aclk = ~aclk;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: the DUT did not finish the stimulus in time");
        $display("Test failed");
        $fatal(1, "watchdog expired");
    end

    function automatic logic [31:0] rand_word();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("Mismatch %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
            $display("Test failed");
            $fatal(1, "stopping at first error");
        end
    endtask

    function automatic logic [31:0] model_read(input mmu_pkg::cp0_sel_e sel);
        case (sel)
            mmu_pkg::CP0_INDEX:    return {m_index_p, 27'd0, m_index};
            mmu_pkg::CP0_ENTRYHI:  return {m_hi_vpn2, 5'd0, m_hi_asid};
            mmu_pkg::CP0_ENTRYLO0: return {6'd0, m_lo0};
            default:               return {6'd0, m_lo1};
        endcase
    endfunction

    function automatic logic entry_match(input int k, input logic [`MMU_VPN2_W-1:0] vpn2);
        return (model_tlb[k].vpn2 == vpn2) && (model_tlb[k].g || model_tlb[k].asid == m_hi_asid);
    endfunction

    function automatic lookup_exp_t predict_lookup(input logic [31:0] va);
        lookup_exp_t want;
        logic        odd;
        want = '0;
        odd  = va[12];      // page 1 of the pair
        for (int k = 0; k < `MMU_ENTRIES; k++) begin
            if (entry_match(k, va[31:13])) begin
                want.found = 1'b1;
                want.v     = odd ? model_tlb[k].v1 : model_tlb[k].v0;
                want.d     = odd ? model_tlb[k].d1 : model_tlb[k].d0;
                want.c     = odd ? model_tlb[k].c1 : model_tlb[k].c0;
                want.paddr = {odd ? model_tlb[k].pfn1 : model_tlb[k].pfn0, va[11:0]};
            end
        end
        return want;
    endfunction

    // state change at the coming edge from pre-edge values
    task automatic model_edge();
        mmu_pkg::tlb_entry_t rd;
        mmu_pkg::tlb_entry_t wr;
        logic                hit;
        logic [3:0]          hit_idx;
        rd      = model_tlb[m_index];
        hit     = 1'b0;
        hit_idx = '0;
        for (int k = 0; k < `MMU_ENTRIES; k++) begin
            if (entry_match(k, m_hi_vpn2)) begin
                hit     = 1'b1;
                hit_idx = k[3:0];
            end
        end
        if (tlb_op == mmu_pkg::TLB_WI) begin
            wr = {m_hi_vpn2, m_hi_asid, m_lo0[0] & m_lo1[0], m_lo0[25:1], m_lo1[25:1]};
            model_tlb[m_index] = wr;
        end
        if (tlb_op == mmu_pkg::TLB_P) begin
            m_index_p = ~hit;
            if (hit) m_index = hit_idx;     // miss keeps the index field
        end else if (cp0_wen && cp0_wsel == mmu_pkg::CP0_INDEX) begin
            m_index_p = cp0_wdata[31];
            m_index   = cp0_wdata[3:0];
        end
        if (tlb_op == mmu_pkg::TLB_R) begin
            m_hi_vpn2 = rd.vpn2;
            m_hi_asid = rd.asid;
            m_lo0     = {rd.pfn0, rd.c0, rd.d0, rd.v0, rd.g};
            m_lo1     = {rd.pfn1, rd.c1, rd.d1, rd.v1, rd.g};
        end else if (cp0_wen && cp0_wsel == mmu_pkg::CP0_ENTRYHI) begin
            m_hi_vpn2 = cp0_wdata[31:13];
            m_hi_asid = cp0_wdata[7:0];
        end else if (cp0_wen && cp0_wsel == mmu_pkg::CP0_ENTRYLO0) begin
            m_lo0 = cp0_wdata[25:0];
        end else if (cp0_wen && cp0_wsel == mmu_pkg::CP0_ENTRYLO1) begin
            m_lo1 = cp0_wdata[25:0];
        end
    endtask

    task automatic check_lookup(input string port, input logic pend, input lookup_exp_t want,
                                input logic valid, input logic found, input logic v,
                                input logic d, input logic [2:0] c, input logic [31:0] paddr);
        check_value({port, "_valid"}, 32'(pend), 32'(valid));
        if (pend) begin
            check_value({port, "_found"}, 32'(want.found), 32'(found));
            check_value({port, "_paddr"}, want.paddr, paddr);
            if (want.found) begin
                check_value({port, "_v"}, 32'(want.v), 32'(v));
                check_value({port, "_d"}, 32'(want.d), 32'(d));
                check_value({port, "_c"}, 32'(want.c), 32'(c));
            end
        end
    endtask

    // one clock cycle; inputs were set at the falling edge before the call
    task automatic tick();
        lookup_exp_t i_want;
        lookup_exp_t d_want;
        logic        i_pend;
        logic        d_pend;
        #2;
        check_value("cp0_rdata", model_read(cp0_rsel), cp0_rdata);
        if (i_req) i_expq.push_back(predict_lookup(i_vaddr));
        if (d_req) d_expq.push_back(predict_lookup(d_vaddr));
        model_edge();
        @(posedge aclk);
        @(negedge aclk);
        i_pend = (i_expq.size() != 0);
        d_pend = (d_expq.size() != 0);
        i_want = '0;
        d_want = '0;
        if (i_pend) i_want = i_expq.pop_front();
        if (d_pend) d_want = d_expq.pop_front();
        check_lookup("i", i_pend, i_want, i_valid, i_found, i_v, i_d, i_c, i_paddr);
        check_lookup("d", d_pend, d_want, d_valid, d_found, d_v, d_d, d_c, d_paddr);
        tlb_op  = mmu_pkg::TLB_NONE;
        cp0_wen = 1'b0;
        i_req   = 1'b0;
        d_req   = 1'b0;
    endtask

    task automatic write_cp0(input mmu_pkg::cp0_sel_e sel, input logic [31:0] data);
        cp0_wen   = 1'b1;
        cp0_wsel  = sel;
        cp0_wdata = data;
        tick();
    endtask

    task automatic tlb_operation(input mmu_pkg::tlb_op_e op);
        tlb_op = op;
        tick();
    endtask

    // mapped address of an entry or one with vpn2 bit 18 set that is never mapped
    function automatic logic [31:0] pick_vaddr(input logic [5:0] sel);
        logic [31:0] s;
        s = rand_word();
        if (sel[5:4] == 2'd3) return {1'b1, s[30:0]};
        return {model_tlb[sel[3:0]].vpn2, s[12:0]};
    endfunction

    initial begin
        logic [31:0] r;
        logic [31:0] lo;
        logic [31:0] hi;
        logic [3:0]  k;
        lcg_state = 32'd21;
        rst_n     = 1'b0;
        tlb_op    = mmu_pkg::TLB_NONE;
        cp0_wen   = 1'b0;
        cp0_wsel  = mmu_pkg::CP0_INDEX;
        cp0_wdata = '0;
        cp0_rsel  = mmu_pkg::CP0_INDEX;
        i_req     = 1'b0;
        i_vaddr   = '0;
        d_req     = 1'b0;
        d_vaddr   = '0;
        for (int e = 0; e < `MMU_ENTRIES; e++) model_tlb[e] = '0;
        {m_index_p, m_index, m_hi_vpn2, m_hi_asid, m_lo0, m_lo1} = '0;
        repeat (5) @(posedge aclk);
        @(negedge aclk);
        rst_n = 1'b1;
        check_value("i_valid", 32'd0, 32'(i_valid));
        check_value("d_valid", 32'd0, 32'(d_valid));

        // zeroed entries hit address 0 under asid 0
        i_req   = 1'b1;
        d_req   = 1'b1;
        d_vaddr = 32'h0000_1abc;
        tick();

        for (int n = 0; n < N_RW; n++) begin
            r        = rand_word();
            cp0_rsel = mmu_pkg::cp0_sel_e'(r[3:2]);
            write_cp0(mmu_pkg::cp0_sel_e'(n[1:0]), rand_word());
            cp0_rsel = mmu_pkg::cp0_sel_e'(n[1:0]);     // read back what was written
            tick();
        end

        // fill every entry with the index in the vpn2 low bits so all differ
        for (int e = 0; e < `MMU_ENTRIES; e++) begin
            r = rand_word();
            write_cp0(mmu_pkg::CP0_INDEX, 32'(e));
            write_cp0(mmu_pkg::CP0_ENTRYHI, {1'b0, r[13:0], e[3:0], 5'd0, r[21:14]});
            lo = rand_word();
            write_cp0(mmu_pkg::CP0_ENTRYLO0, {lo[31:1], r[31]});
            lo = rand_word();
            write_cp0(mmu_pkg::CP0_ENTRYLO1, {lo[31:1], r[30]});   // global when both g set
            tlb_operation(mmu_pkg::TLB_WI);
        end

        for (int n = 0; n < N_LOOKUPS; n++) begin
            r        = rand_word();
            i_req    = r[0];
            d_req    = r[1];
            i_vaddr  = pick_vaddr(r[7:2]);
            d_vaddr  = pick_vaddr(r[13:8]);
            cp0_rsel = mmu_pkg::cp0_sel_e'(r[15:14]);
            if (r[18:16] == 3'd0) begin     // switch to the asid of some entry
                k         = r[22:19];
                cp0_wen   = 1'b1;
                cp0_wsel  = mmu_pkg::CP0_ENTRYHI;
                cp0_wdata = {model_tlb[k].vpn2, 5'd0, model_tlb[k].asid};
            end
            tick();
        end

        for (int n = 0; n < N_PROBES; n++) begin
            r = rand_word();
            k = r[3:0];
            case (r[5:4])
                2'd3:    hi = {1'b1, r[23:6], 5'd0, r[31:24]};
                2'd2:    hi = {model_tlb[k].vpn2, 5'd0, r[31:24]};
                default: hi = {model_tlb[k].vpn2, 5'd0, model_tlb[k].asid};
            endcase
            write_cp0(mmu_pkg::CP0_ENTRYHI, hi);
            cp0_rsel = mmu_pkg::CP0_INDEX;
            tlb_operation(mmu_pkg::TLB_P);
            tick();
        end

        for (int n = 0; n < N_READS; n++) begin
            write_cp0(mmu_pkg::CP0_INDEX, rand_word());
            tlb_operation(mmu_pkg::TLB_R);
            cp0_rsel = mmu_pkg::CP0_ENTRYHI;
            tick();
            cp0_rsel = mmu_pkg::CP0_ENTRYLO0;
            tick();
            cp0_rsel = mmu_pkg::CP0_ENTRYLO1;
            tick();
        end

        $display("Test completed successfully");
        $finish;
    end

endmodule

`default_nettype wire
